/* common/status_pkg.sv */
/*
 * Shared constants and the status record layout for the status subsystem.
 * Source 0..2 settings must stay in step with the payload widths at the top.
 * Payloads above 18 bits do not fit the four-byte packet and are not supported.
 */
`default_nettype none

package status_pkg;

    localparam int num_sources = 3;  // generators behind one router

    // command target numbers
    localparam logic [1:0] src_cmd_id_0 = 2'd0;
    localparam logic [1:0] src_cmd_id_1 = 2'd1;
    localparam logic [1:0] src_cmd_id_2 = 2'd2;

    // register addresses sent as the first packet byte
    localparam logic [7:0] src_reg_addr_0 = 8'd7;
    localparam logic [7:0] src_reg_addr_1 = 8'd8;
    localparam logic [7:0] src_reg_addr_2 = 8'd9;

    // payload widths giving 4, 3 and 2 byte packets
    localparam int src_payload_bits_0 = 15;
    localparam int src_payload_bits_1 = 6;
    localparam int src_payload_bits_2 = 2;

    localparam int max_payload_bits = 18;  // widest payload in four bytes
    localparam int max_packet_bytes = 4;   // address byte included

    // generator modes from cmd_data[7:6]
    localparam logic [1:0] mode_off       = 2'd0;  // no reports
    localparam logic [1:0] mode_single    = 2'd1;  // one report per command
    localparam logic [1:0] mode_auto_keep = 2'd2;  // report on change, seq held
    localparam logic [1:0] mode_auto_inc  = 2'd3;  // report on change, seq counts

    // decoded view of a reassembled packet
    typedef struct packed {
        logic [7:0]  reg_addr;    // byte 0
        logic [15:0] payload_hi;  // payload bits 17:2, bytes 3 and 2
        logic [5:0]  seq;         // byte 1 upper bits
        logic [1:0]  payload_lo;  // byte 1 lower bits
    } status_fields_t;

    // bytes go in through raw and come out through fields
    typedef union packed {
        logic [31:0]    raw;
        status_fields_t fields;
    } status_word_u;

endpackage

`default_nettype wire

/* files.f */
+incdir+test
common/status_pkg.sv
status/status_generate.sv
status/status_router.sv
status/status_receive.sv
verilog/status_top.sv
test/tb_status_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the status subsystem testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module tb_status_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* status/status_generate.sv */
/*
 * Byte-serial status generator. Payload width 2 to 18 bits, packet of 2 to 4 bytes.
 * status is registered once only, so a slow foreign clock domain is assumed.
 * A single request command leaves the running mode in place and only loads seq.
 */
`timescale 1ns/1ps
`default_nettype none

module status_generate #(
    parameter int         payload_bits = status_pkg::src_payload_bits_0,  // 2 to 18
    parameter logic [7:0] reg_addr     = status_pkg::src_reg_addr_0,      // first byte
    parameter logic [1:0] cmd_id       = status_pkg::src_cmd_id_0         // own target number
) (
    input  wire                    rst,         // clock
    input  wire                    clk,         // async reset, active high
    input  wire                    cmd_we,      // command strobe
    input  wire  [1:0]             cmd_target,  // command target number
    input  wire  [7:0]             cmd_data,    // mode in 7:6, seq in 5:0
    input  wire  [payload_bits-1:0] status,     // parallel status word
    output logic [7:0]             ad,          // address or data byte
    output logic                   rq,          // low on the last byte
    input  wire                    start        // router took the address byte
);
    import status_pkg::*;

    localparam int num_bytes = (payload_bits + 21) >> 3;  // address byte included
    localparam int pkt_bits  = (num_bytes - 1) * 8;       // bytes after the address
    localparam int pad_bits  = pkt_bits - 6;              // payload slots in the packet

    logic                    cmd_hit;      // command for this source
    logic [1:0]              cmd_mode;
    logic [1:0]              mode;
    logic [5:0]              seq;
    logic [payload_bits-1:0] status_r0;    // input register
    logic [payload_bits-1:0] status_sent;  // value of the last report
    logic                    changed;      // status moved since last report
    logic                    cmd_pend;     // command asked for a report
    logic                    auto_mode;
    logic                    need_send;
    logic                    snd_rest;     // data bytes after the first one
    logic [pad_bits-1:0]     status_pad;
    logic [pkt_bits-1:0]     data_load;
    logic [pkt_bits-1:0]     data;         // byte shifter, low byte on ad
    logic [num_bytes-2:0]    rq_r;         // request mask, bit 0 is rq

    assign cmd_hit   = cmd_we && (cmd_target == cmd_id);
    assign cmd_mode  = cmd_data[7:6];
    assign auto_mode = (mode == mode_auto_keep) || (mode == mode_auto_inc);
    assign need_send = cmd_pend || changed;
    assign snd_rest  = rq_r[0] && !rq_r[num_bytes-2];  // after start, before last byte

    assign status_pad = pad_bits'(status_r0);  // zero fill up to the byte boundary
    // payload bits 1:0 share byte 1 with seq, the rest fills the upper bytes
    assign data_load  = (pkt_bits'(status_pad >> 2) << 8) |
                        pkt_bits'({seq, status_pad[1:0]});

    assign ad = data[7:0];
    assign rq = rq_r[0];

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            mode        <= mode_off;
            seq         <= '0;
            cmd_pend    <= 1'b0;
            changed     <= 1'b0;
            status_r0   <= '0;
            status_sent <= '0;
            rq_r        <= '0;
        end else begin
            status_r0 <= status;
            if (cmd_hit && (cmd_mode != mode_single))
                mode <= cmd_mode;                // single keeps the running mode
            if (cmd_hit)
                seq <= cmd_data[5:0];
            else if (start && (mode == mode_auto_inc))
                seq <= seq + 6'd1;               // wraps 63 to 0
            if (cmd_hit && (cmd_mode != mode_off))
                cmd_pend <= 1'b1;
            else if (start)
                cmd_pend <= 1'b0;
            if (start)
                changed <= 1'b0;
            else if (auto_mode && (status_r0 != status_sent))
                changed <= 1'b1;
            if (start)
                status_sent <= status_r0;        // the value going out now
            if (need_send && !rq_r[0])
                rq_r <= '1;                      // raise rq and hold until start
            else if (start || snd_rest)
                rq_r <= rq_r >> 1;
        end
    end

    always_ff @(posedge rst) begin
        if (start)
            data <= data_load;                   // seq byte shows next cycle
        else if (snd_rest)
            data <= data >> 8;
        else
            data <= pkt_bits'(reg_addr);         // idle shows the address
    end

endmodule

`default_nettype wire

/* status/status_receive.sv */
/*
 * Status packet receiver. Accepts one byte per valid cycle, no stall.
 * Packets of up to four bytes, bytes not received read as zero.
 * Output fields hold their value until the next st_valid.
 */
`timescale 1ns/1ps
`default_nettype none

module status_receive (
    input  wire                                     rst,         // clock
    input  wire                                     clk,         // async reset, active high
    input  wire                                     byte_valid,
    input  wire                                     byte_last,
    input  wire  [7:0]                              byte_data,
    output logic                                    st_valid,    // one cycle per packet
    output logic [7:0]                              st_addr,
    output logic [5:0]                              st_seq,
    output logic [status_pkg::max_payload_bits-1:0] st_payload
);
    import status_pkg::*;

    localparam int cnt_bits = $clog2(max_packet_bytes);

    logic [cnt_bits-1:0] byte_cnt;   // byte number inside the packet
    logic [cnt_bits-1:0] byte_pos;   // byte slot in the raw word
    status_word_u        word_r;
    status_word_u        word_nxt;

    // address lands in the top slot, the following bytes fill from slot 0 up
    assign byte_pos = byte_cnt - 1'b1;

    always_comb begin
        word_nxt = word_r;
        if (byte_cnt == '0)
            word_nxt.raw = '0;                   // new packet starts clean
        word_nxt.raw[{byte_pos, 3'b000} +: 8] = byte_data;
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            byte_cnt <= '0;
            st_valid <= 1'b0;
        end else begin
            st_valid <= byte_valid && byte_last;
            if (byte_valid)
                byte_cnt <= byte_last ? '0 : byte_cnt + 1'b1;
        end
    end

    always_ff @(posedge rst) begin
        if (byte_valid)
            word_r <= word_nxt;
        if (byte_valid && byte_last) begin
            st_addr    <= word_nxt.fields.reg_addr;
            st_seq     <= word_nxt.fields.seq;
            st_payload <= {word_nxt.fields.payload_hi, word_nxt.fields.payload_lo};
        end
    end

endmodule

`default_nettype wire

/* status/status_router.sv */
/*
 * Round-robin router for status packets. One packet at a time, never interleaved.
 * No back-pressure input, the receiver must take a byte on every valid cycle.
 * start is combinational from src_rq and is raised only while idle.
 */
`timescale 1ns/1ps
`default_nettype none

module status_router (
    input  wire                                      rst,         // clock
    input  wire                                      clk,         // async reset, active high
    input  wire  [status_pkg::num_sources-1:0]       src_rq,      // requests
    input  wire  [status_pkg::num_sources-1:0][7:0]  src_ad,      // address or data bytes
    output logic [status_pkg::num_sources-1:0]       src_start,   // address taken
    output logic                                     byte_valid,
    output logic                                     byte_last,
    output logic [7:0]                               byte_data
);
    import status_pkg::*;

    localparam int idx_bits = $clog2(num_sources);

    logic                busy;      // packet in flight
    logic [idx_bits-1:0] gnt;       // source being forwarded
    logic [idx_bits-1:0] rr_ptr;    // first source to look at
    logic [idx_bits-1:0] pick;      // next winner
    logic                any_rq;
    logic                grant;     // start pulse this cycle

    assign any_rq = |src_rq;
    assign grant  = !busy && any_rq;

    // search from rr_ptr around the ring
    always_comb begin
        int  cand;
        logic found;
        pick  = rr_ptr;
        found = 1'b0;
        for (int i = 0; i < num_sources; i++) begin
            cand = (int'(rr_ptr) + i) % num_sources;
            if (!found && src_rq[cand]) begin
                pick  = idx_bits'(cand);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        src_start = '0;
        if (grant)
            src_start[pick] = 1'b1;              // address byte sampled this cycle
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            busy       <= 1'b0;
            gnt        <= '0;
            rr_ptr     <= '0;
            byte_valid <= 1'b0;
            byte_last  <= 1'b0;
        end else if (busy) begin
            byte_valid <= 1'b1;
            byte_last  <= !src_rq[gnt];          // rq low marks the last byte
            if (!src_rq[gnt])
                busy <= 1'b0;                    // free to grant next cycle
        end else if (grant) begin
            busy       <= 1'b1;
            gnt        <= pick;
            rr_ptr     <= (pick == idx_bits'(num_sources - 1)) ? '0 : pick + 1'b1;
            byte_valid <= 1'b1;                  // address byte
            byte_last  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            byte_last  <= 1'b0;
        end
    end

    always_ff @(posedge rst) begin
        byte_data <= busy ? src_ad[gnt] : src_ad[pick];
    end

endmodule

`default_nettype wire

/* test/status_model.svh */
/*
 * Reference model included in the testbench module body after the status_pkg import.
 * One queue of expected records per source with the oldest record first.
 * Exact only while events are spaced so that no two requests of one source overlap.
 */
`ifndef STATUS_MODEL_SVH
`define STATUS_MODEL_SVH

typedef struct packed {
    logic [5:0]  seq;
    logic [17:0] payload;  // status zero extended
} exp_rec_t;

logic [1:0]  m_mode   [3] = '{default: '0};
logic [5:0]  m_seq    [3] = '{default: '0};
logic [17:0] m_status [3] = '{default: '0};  // value on the status inputs
logic [17:0] m_sent   [3] = '{default: '0};  // status carried by the last record
exp_rec_t    exp_q0[$];
exp_rec_t    exp_q1[$];
exp_rec_t    exp_q2[$];

function automatic int pending_count();
    return exp_q0.size() + exp_q1.size() + exp_q2.size();
endfunction

function automatic void queue_record(int src);
    exp_rec_t rec;
    rec.seq     = m_seq[src];
    rec.payload = m_status[src];
    case (src)
        0:       exp_q0.push_back(rec);
        1:       exp_q1.push_back(rec);
        default: exp_q2.push_back(rec);
    endcase
    m_sent[src] = m_status[src];
    if (m_mode[src] == mode_auto_inc)
        m_seq[src] = m_seq[src] + 6'd1;  // wraps 63 to 0
endfunction

function automatic void model_command(int src, logic [1:0] mode, logic [5:0] seq);
    if (src < 3) begin                    // target 3 has no generator
        if (mode != mode_single)
            m_mode[src] = mode;           // single runs under the old mode
        m_seq[src] = seq;
        if (mode != mode_off)
            queue_record(src);
    end
endfunction

function automatic void model_status(int src, logic [17:0] value);
    m_status[src] = value;
    if ((m_mode[src] == mode_auto_keep || m_mode[src] == mode_auto_inc) &&
        value != m_sent[src])
        queue_record(src);
endfunction

function automatic bit pop_expect(int src, output exp_rec_t rec);
    rec = '0;
    if (src == 0 && exp_q0.size() > 0)
        rec = exp_q0.pop_front();
    else if (src == 1 && exp_q1.size() > 0)
        rec = exp_q1.pop_front();
    else if (src == 2 && exp_q2.size() > 0)
        rec = exp_q2.pop_front();
    else
        return 1'b0;
    return 1'b1;
endfunction

`endif

/* test/tb_status_top.sv */
/*
 * Testbench for status_top with directed cases and LCG stimulus, seed 68.
 * Each event drains before the next one, so the model predicts every record.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_status_top;
    import status_pkg::*;

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 16;
    localparam int event_bound     = 60;   // cycles for a burst of records
    localparam int quiet_cycles    = 16;   // stray records show up in here
    localparam int rand_events     = 300;
    localparam int directed_events = 24;
    localparam int watchdog_ns     = (reset_cycles + 100 + (rand_events + directed_events) *
                                      (event_bound + quiet_cycles + 4)) * clk_period;

    logic                          rst;       // clock
    logic                          clk;       // reset
    logic                          cmd_we;
    logic [1:0]                    cmd_target;
    logic [7:0]                    cmd_data;
    logic [src_payload_bits_0-1:0] status_0;
    logic [src_payload_bits_1-1:0] status_1;
    logic [src_payload_bits_2-1:0] status_2;
    wire                           st_valid;
    wire  [7:0]                    st_addr;
    wire  [5:0]                    st_seq;
    wire  [max_payload_bits-1:0]   st_payload;
    logic [31:0]                   lcg_state;

    `include "status_model.svh"

    status_top DUT (.*);

    initial begin
        rst = 1'b0;
        forever #(clk_period / 2) rst = ~rst;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];          // low bits repeat too soon
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic next_slot();
        @(posedge rst);
        #2;
    endtask

    function automatic void set_status(int src, logic [17:0] value);
        logic [17:0] v;
        v = value & 18'((1 << ((src == 0) ? src_payload_bits_0 :
                               (src == 1) ? src_payload_bits_1 : src_payload_bits_2)) - 1);
        if (src == 0)
            status_0 = v[src_payload_bits_0-1:0];
        else if (src == 1)
            status_1 = v[src_payload_bits_1-1:0];
        else
            status_2 = v[src_payload_bits_2-1:0];
        model_status(src, v);
    endfunction

    task automatic drive_command(int src, logic [1:0] mode, logic [5:0] seq);
        next_slot();
        cmd_we     = 1'b1;                // stays high for back to back writes
        cmd_target = 2'(src);
        cmd_data   = {mode, seq};
        model_command(src, mode, seq);
    endtask

    task automatic release_command();
        next_slot();
        cmd_we = 1'b0;
    endtask

    task automatic settle();
        int cyc;
        cyc = 0;
        while (pending_count() > 0 && cyc < event_bound) begin
            @(posedge rst);
            cyc++;
        end
        assert (pending_count() == 0)
            else fail_run($sformatf("record missing, %0d still expected", pending_count()));
        repeat (quiet_cycles) @(posedge rst);
    endtask

    task automatic command_event(int src, logic [1:0] mode, logic [5:0] seq);
        drive_command(src, mode, seq);
        release_command();
        settle();
    endtask

    task automatic status_event(int src, logic [17:0] value);
        next_slot();
        set_status(src, value);
        settle();
    endtask

    task automatic check_record();
        int       src;
        bit       found;
        exp_rec_t rec;
        src = (st_addr == src_reg_addr_0) ? 0 : (st_addr == src_reg_addr_1) ? 1 :
              (st_addr == src_reg_addr_2) ? 2 : 3;
        assert (src < 3)
            else fail_run($sformatf("record arrived with unknown address 0x%0h", st_addr));
        found = pop_expect(src, rec);
        assert (found)
            else fail_run($sformatf("unexpected record from source %0d", src));
        assert (st_seq == rec.seq)
            else fail_run($sformatf("Mismatch st_seq: got 0x%0h, expected 0x%0h",
                                    st_seq, rec.seq));
        assert (st_payload == rec.payload)
            else fail_run($sformatf("Mismatch st_payload: got 0x%0h, expected 0x%0h",
                                    st_payload, rec.payload));
    endtask

    always @(negedge rst) begin           // outputs settled half a cycle after the edge
        if (!clk && st_valid)
            check_record();
    end

    initial begin
        #(watchdog_ns);
        fail_run("timeout, the run did not finish in the expected time");
    end

    initial begin
        logic [15:0] pick;
        clk        = 1'b1;
        cmd_we     = 1'b0;
        cmd_target = '0;
        cmd_data   = '0;
        status_0   = '0;
        status_1   = '0;
        status_2   = '0;
        lcg_state  = 32'd68;
        repeat (reset_cycles) @(posedge rst);
        #2;
        clk = 1'b0;
        settle();                                // idle after reset
        status_event(0, 18'h5a5a);               // mode off, nothing sent
        status_event(1, 18'h2b);
        status_event(2, 18'h2);
        command_event(0, mode_single, 6'd17);    // 4 byte packet
        command_event(1, mode_single, 6'd33);    // 3 bytes
        command_event(2, mode_single, 6'd50);    // 2 bytes
        command_event(0, mode_off, 6'd3);
        status_event(0, 18'h1234);
        command_event(1, mode_auto_keep, 6'd12);
        for (int i = 0; i < 4; i++)
            status_event(1, 18'(lcg_next()));    // seq held at 12
        command_event(0, mode_auto_inc, 6'd62);
        for (int i = 0; i < 4; i++)
            status_event(0, 18'(lcg_next()));    // seq runs through the wrap
        drive_command(0, mode_single, 6'd5);     // all three on consecutive cycles
        drive_command(1, mode_single, 6'd6);
        drive_command(2, mode_single, 6'd7);
        release_command();
        settle();
        command_event(2, mode_auto_inc, 6'd40);
        next_slot();
        set_status(0, 18'(lcg_next()));          // changes in one cycle
        set_status(1, 18'(lcg_next()));
        set_status(2, m_status[2] ^ 18'h3);
        settle();
        for (int n = 0; n < rand_events; n++) begin
            pick = lcg_next();
            if (pick[2])
                command_event(int'(pick[1:0]), pick[4:3], pick[10:5]);
            else
                status_event(int'(pick[1:0]) % 3, 18'(lcg_next()));
        end
        if (pending_count() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_run("records still expected at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* verilog/status_top.sv */
/*
 * Status subsystem top with three generators, one router and one receiver.
 * Single clock domain. Commands select a generator by cmd_target.
 */
`timescale 1ns/1ps
`default_nettype none

module status_top (
    input  wire                                     rst,         // clock
    input  wire                                     clk,         // async reset, active high
    input  wire                                     cmd_we,
    input  wire  [1:0]                              cmd_target,
    input  wire  [7:0]                              cmd_data,    // mode in 7:6, seq in 5:0
    input  wire  [status_pkg::src_payload_bits_0-1:0] status_0,
    input  wire  [status_pkg::src_payload_bits_1-1:0] status_1,
    input  wire  [status_pkg::src_payload_bits_2-1:0] status_2,
    output wire                                     st_valid,
    output wire  [7:0]                              st_addr,
    output wire  [5:0]                              st_seq,
    output wire  [status_pkg::max_payload_bits-1:0] st_payload
);
    import status_pkg::*;

    wire [num_sources-1:0]      src_rq;
    wire [num_sources-1:0]      src_start;
    wire [num_sources-1:0][7:0] src_ad;
    wire                        byte_valid;
    wire                        byte_last;
    wire [7:0]                  byte_data;

    status_generate #(
        .payload_bits (src_payload_bits_0),
        .reg_addr     (src_reg_addr_0),
        .cmd_id       (src_cmd_id_0)
    ) u_gen_0 (
        .rst        (rst),
        .clk        (clk),
        .cmd_we     (cmd_we),
        .cmd_target (cmd_target),
        .cmd_data   (cmd_data),
        .status     (status_0),
        .ad         (src_ad[0]),
        .rq         (src_rq[0]),
        .start      (src_start[0])
    );

    status_generate #(
        .payload_bits (src_payload_bits_1),
        .reg_addr     (src_reg_addr_1),
        .cmd_id       (src_cmd_id_1)
    ) u_gen_1 (
        .rst        (rst),
        .clk        (clk),
        .cmd_we     (cmd_we),
        .cmd_target (cmd_target),
        .cmd_data   (cmd_data),
        .status     (status_1),
        .ad         (src_ad[1]),
        .rq         (src_rq[1]),
        .start      (src_start[1])
    );

    status_generate #(
        .payload_bits (src_payload_bits_2),
        .reg_addr     (src_reg_addr_2),
        .cmd_id       (src_cmd_id_2)
    ) u_gen_2 (
        .rst        (rst),
        .clk        (clk),
        .cmd_we     (cmd_we),
        .cmd_target (cmd_target),
        .cmd_data   (cmd_data),
        .status     (status_2),
        .ad         (src_ad[2]),
        .rq         (src_rq[2]),
        .start      (src_start[2])
    );

    status_router u_router (
        .rst        (rst),
        .clk        (clk),
        .src_rq     (src_rq),
        .src_ad     (src_ad),
        .src_start  (src_start),
        .byte_valid (byte_valid),
        .byte_last  (byte_last),
        .byte_data  (byte_data)
    );

    status_receive u_receive (
        .rst        (rst),
        .clk        (clk),
        .byte_valid (byte_valid),
        .byte_last  (byte_last),
        .byte_data  (byte_data),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_seq     (st_seq),
        .st_payload (st_payload)
    );

endmodule

`default_nettype wire
